/* build.f */
design/mem_cfg_pkg.sv
design/mem_types_pkg.sv
design/request_queue.sv
design/memory_model.sv
design/resp_buffer.sv
design/mem_subsys_top.sv
verification/mem_subsys_sva.sv
verification/mem_subsys_tb.sv

/* design/mem_cfg_pkg.sv */
package mem_cfg_pkg;

   // Request fields
   localparam int unsigned addr_width  = 8;
   localparam int unsigned data_width  = 32;
   localparam int unsigned index_width = 4;     // Client tag, one per outstanding read

   // Default depths for the queues and the backing array
   localparam int unsigned default_entries_no      = 12;
   localparam int unsigned default_data_entries_no = 4;
   localparam int unsigned default_mem_words       = 256;
   localparam int unsigned default_resp_entries_no = 4;

endpackage

/* design/mem_subsys_top.sv */
`timescale 1ns/1ns

module mem_subsys_top #(
   parameter int unsigned entries_no      = mem_cfg_pkg::default_entries_no,
   parameter int unsigned data_entries_no = mem_cfg_pkg::default_data_entries_no,
   parameter int unsigned mem_words       = mem_cfg_pkg::default_mem_words,
   parameter int unsigned resp_entries_no = mem_cfg_pkg::default_resp_entries_no
) (
   input  logic                                clk,
   input  logic                                rst_n,
   input  mem_types_pkg::mem_request_t         req_i,
   input  logic [mem_cfg_pkg::index_width-1:0] index_i,
   input  logic                                req_valid_i,
   output logic                                req_grant_o,
   output mem_types_pkg::mem_response_t        resp_o,
   output logic                                resp_valid_o,
   input  logic                                resp_grant_i
);

   mem_types_pkg::mem_request_t         issue_req;
   logic [mem_cfg_pkg::index_width-1:0] issue_index;
   logic                                issue_valid;
   logic                                issue_grant;
   mem_types_pkg::mem_response_t        model_resp;
   logic                                model_resp_valid;
   logic                                buf_grant;

   request_queue #(
      .entries_no      (entries_no),
      .data_entries_no (data_entries_no)
   ) u_request_queue (
      .clk       (clk),
      .rst_n     (rst_n),
      .request_i (req_i),
      .index_i   (index_i),
      .valid_i   (req_valid_i),
      .grant_o   (req_grant_o),
      .request_o (issue_req),
      .index_o   (issue_index),
      .valid_o   (issue_valid),
      .grant_i   (issue_grant)
   );

   memory_model #(
      .mem_words (mem_words)
   ) u_memory_model (
      .clk          (clk),
      .rst_n        (rst_n),
      .request_i    (issue_req),
      .index_i      (issue_index),
      .valid_i      (issue_valid),
      .grant_o      (issue_grant),
      .resp_grant_i (buf_grant),
      .resp_o       (model_resp),
      .resp_valid_o (model_resp_valid)
   );

   resp_buffer #(
      .payload_t (mem_types_pkg::mem_response_t),
      .depth     (resp_entries_no)
   ) u_resp_buffer (
      .clk     (clk),
      .rst_n   (rst_n),
      .data_i  (model_resp),
      .valid_i (model_resp_valid),
      .grant_o (buf_grant),
      .data_o  (resp_o),
      .valid_o (resp_valid_o),
      .grant_i (resp_grant_i)
   );

endmodule

/* design/mem_types_pkg.sv */
package mem_types_pkg;

   typedef enum logic {
      read  = 1'b0,
      write = 1'b1
   } req_type_e;

   // What the client sends
   typedef struct packed {
      req_type_e                          req_type;
      logic [mem_cfg_pkg::addr_width-1:0] address;
      logic [mem_cfg_pkg::data_width-1:0] data;      // Don't care for reads
   } mem_request_t;

   // One slot of the request queue's header store
   typedef struct packed {
      req_type_e                           req_type;
      logic [mem_cfg_pkg::addr_width-1:0]  address;
      logic [mem_cfg_pkg::index_width-1:0] index;
   } req_header_t;

   // Read data returned to the client
   typedef struct packed {
      logic [mem_cfg_pkg::index_width-1:0] index;
      logic [mem_cfg_pkg::data_width-1:0]  data;
   } mem_response_t;

endpackage

/* design/memory_model.sv */
`timescale 1ns/1ns

module memory_model #(
   parameter int unsigned mem_words = mem_cfg_pkg::default_mem_words
) (
   input  logic                                clk,
   input  logic                                rst_n,
   // Issue side, from the request queue
   input  mem_types_pkg::mem_request_t         request_i,
   input  logic [mem_cfg_pkg::index_width-1:0] index_i,
   input  logic                                valid_i,
   output logic                                grant_o,
   // Response side, toward the response buffer
   input  logic                                resp_grant_i,
   output mem_types_pkg::mem_response_t        resp_o,
   output logic                                resp_valid_o
);

   localparam int unsigned word_w = (mem_words > 1) ? $clog2(mem_words) : 1;

   logic [mem_cfg_pkg::data_width-1:0] mem_q [mem_words] = '{default: '0};

   logic [word_w-1:0]            word_addr;
   logic                         is_write;
   logic                         transfer;
   mem_types_pkg::mem_response_t resp_q;
   logic                         resp_valid_q;

   assign word_addr = word_w'(32'(request_i.address) % 32'(mem_words));
   assign is_write  = (request_i.req_type == mem_types_pkg::write);

   // A read waits while a response is still in flight, so the buffer always has room for it
   assign grant_o  = resp_grant_i && (!resp_valid_q || is_write);
   assign transfer = valid_i && grant_o;

   always_ff @(posedge clk) begin
      if (transfer && is_write) begin
         mem_q[word_addr] <= request_i.data;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         resp_valid_q <= 1'b0;
      end else begin
         resp_valid_q <= transfer && !is_write;     // One cycle per accepted read
      end
   end

   always_ff @(posedge clk) begin
      if (transfer && !is_write) begin
         resp_q.index <= index_i;
         resp_q.data  <= mem_q[word_addr];
      end
   end

   assign resp_o       = resp_q;
   assign resp_valid_o = resp_valid_q;

endmodule

/* design/request_queue.sv */
`timescale 1ns/1ns

module request_queue #(
   parameter int unsigned entries_no      = mem_cfg_pkg::default_entries_no,
   parameter int unsigned data_entries_no = mem_cfg_pkg::default_data_entries_no
) (
   input  logic                                clk,
   input  logic                                rst_n,
   // Push side
   input  mem_types_pkg::mem_request_t         request_i,
   input  logic [mem_cfg_pkg::index_width-1:0] index_i,
   input  logic                                valid_i,
   output logic                                grant_o,
   // Pop side
   output mem_types_pkg::mem_request_t         request_o,
   output logic [mem_cfg_pkg::index_width-1:0] index_o,
   output logic                                valid_o,
   input  logic                                grant_i
);

   localparam int unsigned hdr_ptr_w  = (entries_no > 1) ? $clog2(entries_no) : 1;
   localparam int unsigned data_ptr_w = (data_entries_no > 1) ? $clog2(data_entries_no) : 1;
   localparam int unsigned data_cnt_w = $clog2(data_entries_no + 1);

   typedef enum logic [1:0] {
      st_empty,
      st_middle,
      st_full
   } occ_state_e;

   occ_state_e state_q;
   occ_state_e state_d;

   logic [hdr_ptr_w-1:0]  hdr_push_q;
   logic [hdr_ptr_w-1:0]  hdr_pop_q;
   logic [hdr_ptr_w-1:0]  hdr_push_nxt;
   logic [hdr_ptr_w-1:0]  hdr_pop_nxt;
   logic [data_ptr_w-1:0] data_push_q;
   logic [data_ptr_w-1:0] data_pop_q;
   logic [data_cnt_w-1:0] data_cnt_q;

   mem_types_pkg::req_header_t         hdr_mem [entries_no];
   logic [mem_cfg_pkg::data_width-1:0] data_mem [data_entries_no];
   mem_types_pkg::req_header_t         hdr_head;

   logic push;
   logic pop;
   logic push_write;
   logic pop_write;
   logic data_full;

   assign hdr_head = hdr_mem[hdr_pop_q];

   // Conservative: a full data store blocks reads as well
   assign data_full = (data_cnt_q == data_cnt_w'(data_entries_no));
   assign grant_o   = (state_q != st_full) && !data_full;
   assign valid_o   = (state_q != st_empty);

   assign push       = valid_i && grant_o;
   assign pop        = valid_o && grant_i;
   assign push_write = push && (request_i.req_type == mem_types_pkg::write);
   assign pop_write  = pop && (hdr_head.req_type == mem_types_pkg::write);

   assign hdr_push_nxt = (hdr_push_q == hdr_ptr_w'(entries_no - 1)) ? '0 : hdr_push_q + 1'b1;
   assign hdr_pop_nxt  = (hdr_pop_q == hdr_ptr_w'(entries_no - 1)) ? '0 : hdr_pop_q + 1'b1;

   always_comb begin
      case ({push, pop})
         2'b10:   state_d = (hdr_push_nxt == hdr_pop_q) ? st_full : st_middle;
         2'b01:   state_d = (hdr_pop_nxt == hdr_push_q) ? st_empty : st_middle;
         default: state_d = state_q;     // Push and pop together leave occupancy as is
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state_q    <= st_empty;
         hdr_push_q <= '0;
         hdr_pop_q  <= '0;
      end else begin
         state_q <= state_d;
         if (push) begin
            hdr_push_q <= hdr_push_nxt;
         end
         if (pop) begin
            hdr_pop_q <= hdr_pop_nxt;
         end
      end
   end

   // Data pointers only move for writes
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         data_push_q <= '0;
         data_pop_q  <= '0;
         data_cnt_q  <= '0;
      end else begin
         if (push_write) begin
            data_push_q <= (data_push_q == data_ptr_w'(data_entries_no - 1)) ?
                           '0 : data_push_q + 1'b1;
         end
         if (pop_write) begin
            data_pop_q <= (data_pop_q == data_ptr_w'(data_entries_no - 1)) ?
                          '0 : data_pop_q + 1'b1;
         end
         case ({push_write, pop_write})
            2'b10:   data_cnt_q <= data_cnt_q + 1'b1;
            2'b01:   data_cnt_q <= data_cnt_q - 1'b1;
            default: data_cnt_q <= data_cnt_q;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (push) begin
         hdr_mem[hdr_push_q] <= '{req_type: request_i.req_type,
                                  address:  request_i.address,
                                  index:    index_i};
      end
      if (push_write) begin
         data_mem[data_push_q] <= request_i.data;
      end
   end

   // Oldest header, paired with the oldest write word
   assign request_o = '{req_type: hdr_head.req_type,
                        address:  hdr_head.address,
                        data:     data_mem[data_pop_q]};
   assign index_o   = hdr_head.index;

endmodule

/* design/resp_buffer.sv */
`timescale 1ns/1ns

module resp_buffer #(
   parameter type         payload_t = logic [7:0],
   parameter int unsigned depth     = mem_cfg_pkg::default_resp_entries_no
) (
   input  logic     clk,
   input  logic     rst_n,
   input  payload_t data_i,
   input  logic     valid_i,
   output logic     grant_o,
   output payload_t data_o,
   output logic     valid_o,
   input  logic     grant_i
);

   localparam int unsigned ptr_w = (depth > 1) ? $clog2(depth) : 1;
   localparam int unsigned cnt_w = $clog2(depth + 1);

   payload_t store_q [depth];

   logic [ptr_w-1:0] wr_ptr_q;
   logic [ptr_w-1:0] rd_ptr_q;
   logic [cnt_w-1:0] count_q;
   logic             wr_en;
   logic             rd_en;

   assign grant_o = (count_q < cnt_w'(depth));
   assign valid_o = (count_q != '0);
   assign data_o  = store_q[rd_ptr_q];     // Head entry, valid only with valid_o

   assign wr_en = valid_i && grant_o;
   assign rd_en = valid_o && grant_i;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (wr_en) begin
            wr_ptr_q <= (wr_ptr_q == ptr_w'(depth - 1)) ? '0 : wr_ptr_q + 1'b1;
         end
         if (rd_en) begin
            rd_ptr_q <= (rd_ptr_q == ptr_w'(depth - 1)) ? '0 : rd_ptr_q + 1'b1;
         end
         case ({wr_en, rd_en})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (wr_en) begin
         store_q[wr_ptr_q] <= data_i;
      end
   end

endmodule

/* run_sim.sh */
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module mem_subsys_tb -f build.f

output=$(./obj_dir/Vmem_subsys_tb)
echo "$output"

echo "$output" | grep -qx "all tests passed"

/* verification/mem_subsys_sva.sv */
`timescale 1ns/1ns

module mem_subsys_sva #(
   parameter int unsigned entries_no      = mem_cfg_pkg::default_entries_no,
   parameter int unsigned data_entries_no = mem_cfg_pkg::default_data_entries_no
) (
   input logic        clk,
   input logic        rst_n,
   input logic        push_valid_i,
   input logic        push_write_i,
   input logic        q_grant_i,
   input logic        q_valid_i,
   input logic        pop_grant_i,
   input logic        pop_write_i,
   input logic [31:0] push_ptr_i
);

   int unsigned hdr_cnt_q;     // Occupancy rebuilt from the handshakes on both sides
   int unsigned data_cnt_q;
   logic        push;
   logic        pop;

   assign push = push_valid_i && q_grant_i;
   assign pop  = q_valid_i && pop_grant_i;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         hdr_cnt_q  <= 0;
         data_cnt_q <= 0;
      end else begin
         hdr_cnt_q  <= hdr_cnt_q + 32'(push) - 32'(pop);
         data_cnt_q <= data_cnt_q + 32'(push && push_write_i) - 32'(pop && pop_write_i);
      end
   end

   grant_tracks_room: assert property (@(posedge clk) disable iff (!rst_n)
      q_grant_i == !(hdr_cnt_q == entries_no || data_cnt_q == data_entries_no))
      else $error("Request queue grant disagrees with store occupancy");

   no_valid_when_empty: assert property (@(posedge clk) disable iff (!rst_n)
      (hdr_cnt_q == 0) |-> !q_valid_i)
      else $error("Request queue offers an entry while empty");

   // The push pointer only moves on an accepted push
   no_push_without_grant: assert property (@(posedge clk) disable iff (!rst_n)
      !q_grant_i |=> $stable(push_ptr_i))
      else $error("Request queue took a push while grant was low");

endmodule

bind request_queue mem_subsys_sva #(
   .entries_no      (entries_no),
   .data_entries_no (data_entries_no)
) u_flow_sva (
   .clk          (clk),
   .rst_n        (rst_n),
   .push_valid_i (valid_i),
   .push_write_i (request_i.req_type == mem_types_pkg::write),
   .q_grant_i    (grant_o),
   .q_valid_i    (valid_o),
   .pop_grant_i  (grant_i),
   .pop_write_i  (request_o.req_type == mem_types_pkg::write),
   .push_ptr_i   (32'(hdr_push_q))
);

/* verification/mem_subsys_tb.sv */
`timescale 1ns/1ns

module mem_subsys_tb;

   localparam int unsigned entries_no      = 12;
   localparam int unsigned data_entries_no = 4;
   localparam int unsigned mem_words       = 256;
   localparam int unsigned resp_entries_no = 4;
   localparam int unsigned max_vectors     = 128;
   localparam int unsigned probe_window    = 8;     // Cycles a probe request is offered
   localparam int unsigned drain_limit     = 200;

   localparam logic [3:0] kind_idle  = 4'h0;
   localparam logic [3:0] kind_req   = 4'h1;
   localparam logic [3:0] kind_probe = 4'h2;

   typedef struct packed {
      logic [3:0]  test_id;
      logic [3:0]  kind;
      logic [3:0]  op;
      logic [7:0]  address;
      logic [31:0] data;
      logic [3:0]  index;
      logic [3:0]  resp_grant;
      logic [31:0] expected;
   } vector_t;

   logic                                clk;
   logic                                rst_n;
   mem_types_pkg::mem_request_t         req;
   logic [mem_cfg_pkg::index_width-1:0] index;
   logic                                req_valid;
   logic                                req_grant;
   mem_types_pkg::mem_response_t        resp;
   logic                                resp_valid;
   logic                                resp_grant;

   logic [91:0]                        vector_mem [max_vectors];
   logic [mem_cfg_pkg::data_width-1:0] ref_mem [mem_words];
   mem_types_pkg::mem_response_t       expected_q [$];

   int num_vectors     = 0;
   int errors          = 0;
   int test_errors     = 0;
   int checks          = 0;
   int tests_run       = 0;
   int tests_bad       = 0;
   int probes_accepted = 0;

   mem_subsys_top #(
      .entries_no      (entries_no),
      .data_entries_no (data_entries_no),
      .mem_words       (mem_words),
      .resp_entries_no (resp_entries_no)
   ) u_dut (
      .clk          (clk),
      .rst_n        (rst_n),
      .req_i        (req),
      .index_i      (index),
      .req_valid_i  (req_valid),
      .req_grant_o  (req_grant),
      .resp_o       (resp),
      .resp_valid_o (resp_valid),
      .resp_grant_i (resp_grant)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   task automatic note_error();
      errors++;
      test_errors++;
   endtask

   function automatic int probes_expected(input logic [3:0] test_id);
      case (test_id)
         4'd3:    return int'(data_entries_no);     // Data store caps the write burst
         4'd4:    return int'(entries_no + resp_entries_no);
         default: return 0;
      endcase
   endfunction

   task automatic report_test(input int test_id);
      tests_run++;
      if (test_errors == 0) begin
         $display("test %0d ok", test_id);
      end else begin
         tests_bad++;
         $display("test %0d FAIL with %0d errors", test_id, test_errors);
      end
      test_errors     = 0;
      probes_accepted = 0;
   endtask

   // Track what the memory must hold once the request is accepted
   task automatic record_accept(input vector_t v);
      mem_types_pkg::mem_response_t exp_resp;
      if (v.op[0]) begin
         ref_mem[v.address] = v.data;
      end else begin
         exp_resp.index = v.index;
         exp_resp.data  = ref_mem[v.address];
         expected_q.push_back(exp_resp);
         if (v.expected !== ref_mem[v.address]) begin
            $display("ERROR: vector file expects %h at address %h, write history gives %h",
                     v.expected, v.address, ref_mem[v.address]);
            note_error();
         end
      end
   endtask

   task automatic offer_request(input vector_t v);
      int  waited;
      logic accepted;
      waited   = 0;
      accepted = 1'b0;
      req.req_type = v.op[0] ? mem_types_pkg::write : mem_types_pkg::read;
      req.address  = v.address;
      req.data     = v.data;
      index        = v.index;
      req_valid    = 1'b1;
      while (!accepted && (v.kind != kind_probe || waited < int'(probe_window))) begin
         @(negedge clk);
         if (req_grant) begin
            accepted = 1'b1;
            record_accept(v);
            if (v.kind == kind_probe) begin
               probes_accepted++;
            end
         end
         @(posedge clk);
         #1;
         waited++;
      end
      req_valid = 1'b0;
   endtask

   task automatic finish_test(input vector_t v);
      int waited;
      waited = 0;
      while (expected_q.size() != 0 && waited < int'(drain_limit)) begin
         @(posedge clk);
         #1;
         waited++;
      end
      if (expected_q.size() != 0) begin
         $display("ERROR: %0d read responses never came back", expected_q.size());
         note_error();
      end
      if (probes_expected(v.test_id) != 0) begin
         checks++;
         assert (probes_accepted == probes_expected(v.test_id)) else begin
            $display("MISMATCH req_grant_o accepted burst count expected %h got %h",
                     probes_expected(v.test_id), probes_accepted);
            note_error();
         end
      end
      report_test(int'(v.test_id));
   endtask

   task automatic run_step(input vector_t v);
      resp_grant = v.resp_grant[0];
      if (v.kind == kind_idle) begin
         repeat (v.data) begin
            @(posedge clk);
            #1;
         end
      end else if (v.kind == kind_req || v.kind == kind_probe) begin
         offer_request(v);
      end else begin
         finish_test(v);
      end
   endtask

   // A response transfers on the next rising edge
   always @(negedge clk) begin
      mem_types_pkg::mem_response_t exp_resp;
      if (rst_n && resp_valid && resp_grant) begin
         if (expected_q.size() == 0) begin
            $display("ERROR: response with index %h arrived with no read outstanding",
                     resp.index);
            note_error();
         end else begin
            exp_resp = expected_q.pop_front();
            checks++;
            assert (resp.index == exp_resp.index) else begin
               $display("MISMATCH resp_o.index expected %h got %h", exp_resp.index, resp.index);
               note_error();
            end
            assert (resp.data == exp_resp.data) else begin
               $display("MISMATCH resp_o.data expected %h got %h", exp_resp.data, resp.data);
               note_error();
            end
         end
      end
   end

   initial begin
      int limit;
      wait (num_vectors > 0);
      limit = num_vectors * 40 + 200;
      repeat (limit) @(posedge clk);
      $display("ERROR: watchdog expired after %0d cycles, the run did not finish", limit);
      $display("tests failed");
      $finish;
   end

   initial begin
      int n;
      rst_n      = 1'b0;
      req        = '0;
      index      = '0;
      req_valid  = 1'b0;
      resp_grant = 1'b0;
      for (int i = 0; i < int'(mem_words); i++) begin
         ref_mem[i] = '0;
      end
      $readmemh("verification/mem_subsys_vectors.txt", vector_mem);
      n = 0;
      while (n < int'(max_vectors) && !$isunknown(vector_mem[n]) && vector_mem[n] != '0) begin
         n++;
      end
      if (n == 0) begin
         $display("ERROR: no vectors were loaded");
         note_error();
      end
      num_vectors = n;
      repeat (8) @(posedge clk);
      #1;
      rst_n = 1'b1;
      @(posedge clk);
      #1;
      checks++;
      assert (req_grant == 1'b1 && resp_valid == 1'b0) else begin
         $display("MISMATCH req_grant_o/resp_valid_o expected 1/0 got %h/%h",
                  req_grant, resp_valid);
         note_error();
      end
      report_test(1);
      for (int i = 0; i < num_vectors; i++) begin
         run_step(vector_t'(vector_mem[i]));
      end
      $display("tests run %0d, tests with errors %0d, checks %0d, errors %0d",
               tests_run, tests_bad, checks, errors);
      if (errors == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

endmodule

/* verification/mem_subsys_vectors.txt */
// test_kind_op_addr_data_index_respgrant_expected, all hex
// kind 0 idle for data cycles, 1 request, 2 burst probe, 3 end of test; op 1 is write
2_1_1_10_11111111_0_1_00000000
2_1_1_20_22222222_1_1_00000000
2_1_0_10_00000000_2_1_11111111
2_1_1_10_33333333_3_1_00000000
2_1_0_20_00000000_4_1_22222222
2_1_0_10_00000000_5_1_33333333
2_3_0_00_00000000_0_1_00000000
3_1_0_10_00000000_6_0_33333333
3_1_0_20_00000000_7_0_22222222
3_1_0_30_00000000_8_0_00000000
3_1_0_40_00000000_9_0_00000000
3_0_0_00_00000010_0_0_00000000
3_2_1_50_50505050_0_0_00000000
3_2_1_51_51515151_0_0_00000000
3_2_1_52_52525252_0_0_00000000
3_2_1_53_53535353_0_0_00000000
3_2_1_54_54545454_0_0_00000000
3_2_1_55_55555555_0_0_00000000
3_1_0_53_00000000_A_1_53535353
3_1_0_54_00000000_B_1_00000000
3_3_0_00_00000000_0_1_00000000
4_2_0_10_00000000_0_0_33333333
4_2_0_20_00000000_1_0_22222222
4_2_0_10_00000000_2_0_33333333
4_2_0_20_00000000_3_0_22222222
4_2_0_10_00000000_4_0_33333333
4_2_0_20_00000000_5_0_22222222
4_2_0_10_00000000_6_0_33333333
4_2_0_20_00000000_7_0_22222222
4_2_0_10_00000000_8_0_33333333
4_2_0_20_00000000_9_0_22222222
4_2_0_10_00000000_A_0_33333333
4_2_0_20_00000000_B_0_22222222
4_2_0_10_00000000_C_0_33333333
4_2_0_20_00000000_D_0_22222222
4_2_0_10_00000000_E_0_33333333
4_2_0_20_00000000_F_0_22222222
4_2_0_10_00000000_0_0_33333333
4_2_0_20_00000000_1_0_22222222
4_3_0_00_00000000_0_1_00000000
5_1_0_77_00000000_C_1_00000000
5_1_0_88_00000000_D_1_00000000
5_1_0_FF_00000000_E_1_00000000
5_3_0_00_00000000_0_1_00000000
6_1_1_61_9C3E0A17_0_0_00000000
6_1_0_61_00000000_1_1_9C3E0A17
6_1_1_63_4F2B88D1_2_1_00000000
6_1_0_60_00000000_3_0_00000000
6_1_1_61_07E5C3A9_4_1_00000000
6_1_0_63_00000000_5_0_4F2B88D1
6_1_1_60_B1D46E02_6_0_00000000
6_1_0_61_00000000_7_1_07E5C3A9
6_1_0_60_00000000_8_0_B1D46E02
6_1_1_63_2A7F9135_9_1_00000000
6_1_0_63_00000000_A_0_2A7F9135
6_1_0_62_00000000_B_1_00000000
6_3_0_00_00000000_0_1_00000000
